//--- dmdDriver.sv
module dmdDriver #(
	parameter dmdPkg::rasterCount_t hFront = 16'd37,
	parameter dmdPkg::rasterCount_t hBack = 16'd998,
	parameter dmdPkg::rasterCount_t hSync = 16'd1024,
	parameter dmdPkg::rasterCount_t hTotal = 16'd1039,
	parameter dmdPkg::rasterCount_t vFront = 16'd22,
	parameter dmdPkg::rasterCount_t vBack = 16'd1104,
	parameter dmdPkg::rasterCount_t vSyncStart = 16'd1107,
	parameter dmdPkg::rasterCount_t vTotal = 16'd1111,
	parameter int dmdWidth = 128,				// Dots per row
	parameter int dotPairs = 8,					// Pixel slots per dot
	parameter int dotLines = 15					// Lines per dot
) (
	input  logic bit_clock_out,
	input  logic reset,
	input  logic dotClock,
	input  logic dotData,
	input  logic dotLatch,
	input  logic [2:0] dotReg,
	output logic pairClk,
	output logic pair2,
	output logic pair1,
	output logic pair0
);

	logic pixelWrite;
	dmdPkg::dotByte_t pixelData;
	logic frameDone;
	dmdPkg::dmdSettings_t dmdSettings;
	dmdPkg::bufAddr_t readAddr;
	dmdPkg::dotByte_t readData;
	logic slotStrobe;
	dmdPkg::rasterPos_t raster;
	logic pixelValid;
	dmdPkg::pixelOut_t pixel;

	// Only dotReg[0] picks dot or setting bytes
	dotReceiver receiver (
		.bit_clock_out(bit_clock_out),
		.reset(reset),
		.dotClock(dotClock),
		.dotData(dotData),
		.dotLatch(dotLatch),
		.dotReg(dotReg[0]),
		.pixelWrite(pixelWrite),
		.pixelData(pixelData),
		.frameDone(frameDone),
		.dmdSettings(dmdSettings)
	);

	frameBuffer buffer (
		.bit_clock_out(bit_clock_out),
		.reset(reset),
		.pixelWrite(pixelWrite),
		.pixelData(pixelData),
		.frameDone(frameDone),
		.readAddr(readAddr),
		.readData(readData)
	);

	rasterTiming #(
		.hFront(hFront),
		.hBack(hBack),
		.hSync(hSync),
		.hTotal(hTotal),
		.vFront(vFront),
		.vBack(vBack),
		.vSyncStart(vSyncStart),
		.vTotal(vTotal)
	) timing (
		.bit_clock_out(bit_clock_out),
		.reset(reset),
		.slotStrobe(slotStrobe),
		.raster(raster)
	);

	pixelFetch #(
		.vFront(vFront),
		.dmdWidth(dmdWidth),
		.dotPairs(dotPairs),
		.dotLines(dotLines)
	) fetch (
		.bit_clock_out(bit_clock_out),
		.reset(reset),
		.slotStrobe(slotStrobe),
		.raster(raster),
		.dmdSettings(dmdSettings),
		.readAddr(readAddr),
		.readData(readData),
		.pixelValid(pixelValid),
		.pixel(pixel)
	);

	lvdsSerializer serializer (
		.bit_clock_out(bit_clock_out),
		.reset(reset),
		.pixelValid(pixelValid),
		.pixel(pixel),
		.pairClk(pairClk),
		.pair2(pair2),
		.pair1(pair1),
		.pair0(pair0)
	);

endmodule

//--- dmdDriverTb.sv
module dmdDriverTb;

	timeunit 1ns;
	timeprecision 100ps;

	// Small panel so a whole frame decodes quickly
	localparam int hFront = 3;
	localparam int hBack = 40;
	localparam int hSync = 44;
	localparam int hTotal = 47;
	localparam int vFront = 2;
	localparam int vBack = 30;
	localparam int vSyncStart = 27;
	localparam int vTotal = 31;
	localparam int dmdWidth = 4;
	localparam int dotPairs = 4;
	localparam int dotLines = 3;
	localparam int dotBytes = 2 * dmdWidth;					// Two dot rows per byte set
	localparam int frameCycles = (hTotal + 1) * (vTotal + 1) * 7;
	localparam int whiteLevel = 62;
	localparam int colourScale = 9;
	localparam logic [6:0] clockPattern = 7'b1100011;

	logic bit_clock_out = 1'b0;
	logic reset;
	logic dotClock;
	logic dotData;
	logic dotLatch;
	logic [2:0] dotReg;
	logic pairClk;
	logic pair2;
	logic pair1;
	logic pair0;

	dmdPkg::pixelOut_t frame [0:vTotal][0:hTotal];		// Last decoded pixel per line and slot
	dmdPkg::dotByte_t dotSets [0:1][0:dotBytes-1];		// Two random byte sets
	int frameCount = 0;									// Complete frames decoded
	int pixelErrors = 0;
	int clockErrors = 0;
	int timeoutErrors = 0;
	int expWhiteEnd = 50;								// Model of the settings registers
	int expDmdStart = 70;
	int expDmdRows = 64;
	int expSet = 0;										// Byte set in the display bank
	logic [31:0] lfsrState = 32'hd7ca6de2;

	always #2 bit_clock_out = ~bit_clock_out;			// 4 ns period

	dmdDriver #(
		.hFront(hFront),
		.hBack(hBack),
		.hSync(hSync),
		.hTotal(hTotal),
		.vFront(vFront),
		.vBack(vBack),
		.vSyncStart(vSyncStart),
		.vTotal(vTotal),
		.dmdWidth(dmdWidth),
		.dotPairs(dotPairs),
		.dotLines(dotLines)
	) UUT (
		.bit_clock_out(bit_clock_out),
		.reset(reset),
		.dotClock(dotClock),
		.dotData(dotData),
		.dotLatch(dotLatch),
		.dotReg(dotReg),
		.pairClk(pairClk),
		.pair2(pair2),
		.pair1(pair1),
		.pair0(pair0)
	);

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	task automatic nextRandomByte(output dmdPkg::dotByte_t value);
		value = '0;
		for (int i = 0; i < 8; i++)
		begin
			lfsrState = lfsrStep(lfsrState);			// One step per bit
			value = {value[6:0], lfsrState[0]};
		end
	endtask

	// 3-3-2 to 6-6-6 with blue gaining a low zero bit before scaling
	function automatic dmdPkg::rgb_t expandDot(input dmdPkg::dotByte_t value);
		dmdPkg::rgb_t c;
		c.red = dmdPkg::colour_t'(value[7:5] * colourScale);
		c.green = dmdPkg::colour_t'(value[4:2] * colourScale);
		c.blue = dmdPkg::colour_t'({value[1:0], 1'b0} * colourScale);
		return c;
	endfunction

	// Pixel the panel should see at slot h of line v
	function automatic dmdPkg::pixelOut_t expectedPixel(input int h, input int v);
		dmdPkg::pixelOut_t p;
		int row;
		int col;
		p.dataEnable = (h > hFront) && (h < hBack) && (v > vFront) && (v < vBack);
		p.hSync = (h < hSync);								// Active low
		p.vSync = (v < vSyncStart);
		p.colour = '0;
		if (p.dataEnable && v < vFront + expWhiteEnd)
			p.colour = '{whiteLevel, whiteLevel, whiteLevel};
		else if (p.dataEnable && v >= vFront + expDmdStart)
		begin
			row = (v - vFront - expDmdStart) / dotLines;
			col = (h - hFront - 1) / dotPairs;			// Columns start at first enabled slot
			if (row < expDmdRows && col < dmdWidth && row * dmdWidth + col < dotBytes)
				p.colour = expandDot(dotSets[expSet][row * dmdWidth + col]);
		end
		return p;
	endfunction

	task automatic finishRun();
		$display("Errors: pixel %0d, clock lane %0d, timeout %0d",
			pixelErrors, clockErrors, timeoutErrors);
		if (pixelErrors + clockErrors + timeoutErrors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	endtask

	task automatic waitFrames(input int frames);
		int target;
		int waited;
		target = frameCount + frames;
		waited = 0;
		while (frameCount < target && waited < (frames + 1) * frameCycles)
		begin
			@(posedge bit_clock_out);
			waited++;
		end
		if (frameCount < target)
		begin
			timeoutErrors++;
			$display("Timeout: decoded frames stopped arriving from the lanes");
		end
	endtask

	// Serial bits MSB first with each dotClock level held 4 cycles
	task automatic sendBits(input dmdPkg::dotByte_t value, input int count, input logic isSetting);
		for (int i = 7; i > 7 - count; i--)
		begin
			dotReg <= {2'b00, isSetting};
			dotData <= value[i];
			dotClock <= 1'b0;
			repeat (4) @(posedge bit_clock_out);
			dotClock <= 1'b1;							// Sampled on this edge
			repeat (4) @(posedge bit_clock_out);
		end
		dotClock <= 1'b0;
		repeat (4) @(posedge bit_clock_out);
	endtask

	task automatic sendByte(input dmdPkg::dotByte_t value);
		sendBits(value, 8, 1'b0);
	endtask

	task automatic sendSetting(input dmdPkg::setting_t value);
		sendBits(value[15:8], 8, 1'b1);				// High byte first
		sendBits(value[7:0], 8, 1'b1);
	endtask

	task automatic sendLatch();
		dotLatch <= 1'b1;
		repeat (4) @(posedge bit_clock_out);
		dotLatch <= 1'b0;
		repeat (4) @(posedge bit_clock_out);
	endtask

	task automatic writeDots(input int setIndex);
		for (int i = 0; i < dotBytes; i++)
			sendByte(dotSets[setIndex][i]);
	endtask

	task automatic compareFrame(input int firstLine, input int lastLine, input string label);
		dmdPkg::pixelOut_t want;
		dmdPkg::pixelOut_t got;
		for (int v = firstLine; v <= lastLine; v++)
		begin
			for (int h = 0; h <= hTotal; h++)
			begin
				want = expectedPixel(h, v);
				got = frame[v][h];
				assert (got.colour === want.colour) else
				begin
					pixelErrors++;
					$display("ERROR colour %s line %0d slot %0d: got %h, expected %h",
						label, v, h, got.colour, want.colour);
				end
				assert (got.dataEnable === want.dataEnable) else
				begin
					pixelErrors++;
					$display("ERROR dataEnable %s line %0d slot %0d: got %h, expected %h",
						label, v, h, got.dataEnable, want.dataEnable);
				end
				assert (got.hSync === want.hSync) else
				begin
					pixelErrors++;
					$display("ERROR hSync %s line %0d slot %0d: got %h, expected %h",
						label, v, h, got.hSync, want.hSync);
				end
				assert (got.vSync === want.vSync) else
				begin
					pixelErrors++;
					$display("ERROR vSync %s line %0d slot %0d: got %h, expected %h",
						label, v, h, got.vSync, want.vSync);
				end
			end
		end
	endtask

	// Default settings paint every enabled line white
	task automatic clockAndSyncLevels();
		waitFrames(2);
		compareFrame(0, vTotal, "defaults");
	endtask

	task automatic whiteAndBlackBands();
		sendSetting(16'd3);
		sendSetting(16'd5);
		sendSetting(16'd2);
		expWhiteEnd = 3;
		expDmdStart = 5;
		expDmdRows = 2;
		waitFrames(2);
		compareFrame(0, vFront + expDmdStart - 1, "bands");	// Display bank not written yet
	endtask

	task automatic randomDots();
		for (int i = 0; i < dotBytes; i++)
			nextRandomByte(dotSets[0][i]);
		writeDots(0);
		sendLatch();
		expSet = 0;
		waitFrames(2);								// First frame may straddle the swap
		compareFrame(0, vTotal, "dots");
	endtask

	task automatic bufferHeldUntilLatch();
		for (int i = 0; i < dotBytes; i++)
			nextRandomByte(dotSets[1][i]);
		writeDots(1);
		waitFrames(2);
		compareFrame(0, vTotal, "before latch");		// Old set still showing
		sendLatch();
		expSet = 1;
		waitFrames(2);
		compareFrame(0, vTotal, "after latch");
	endtask

	task automatic extraInputIgnored();
		sendSetting(16'd3);
		sendSetting(16'd5);
		sendSetting(16'd2);
		sendSetting(16'h0001);						// Beyond setting 2
		writeDots(1);
		sendBits(8'ha5, 5, 1'b0);					// Cut off by the latch
		sendLatch();
		writeDots(1);								// Misaligned if the partial byte stuck
		sendLatch();
		waitFrames(2);
		compareFrame(0, vTotal, "extra input");
	endtask

	// Lane decoder sampling on the falling edge
	initial
	begin : laneMonitor
		dmdPkg::laneWord_t clkWord;
		dmdPkg::laneWord_t word2;
		dmdPkg::laneWord_t word1;
		dmdPkg::laneWord_t word0;
		dmdPkg::pixelOut_t seen;
		int h;
		int v;
		int waited;
		h = 1;										// First slot strobe after reset is slot 1
		v = 0;
		waited = 0;
		@(negedge bit_clock_out);
		while ((reset !== 1'b0 || pairClk !== 1'b1) && waited < 200)
		begin
			@(negedge bit_clock_out);
			waited++;
		end
		if (reset === 1'b0 && pairClk === 1'b1)
		begin
			forever
			begin
				for (int i = 0; i < 7; i++)
				begin
					clkWord = {clkWord[5:0], pairClk};
					word2 = {word2[5:0], pair2};
					word1 = {word1[5:0], pair1};
					word0 = {word0[5:0], pair0};
					if (i < 6)
						@(negedge bit_clock_out);
				end
				assert (clkWord == clockPattern) else
				begin
					clockErrors++;
					$display("ERROR pairClk line %0d slot %0d: got %h, expected %h",
						v, h, clkWord, clockPattern);
				end
				seen.dataEnable = word2[6];
				seen.vSync = word2[5];
				seen.hSync = word2[4];
				seen.colour.blue = {word2[3:0], word1[6:5]};
				seen.colour.green = {word1[4:0], word0[6]};	// Green LSB rides on lane 0
				seen.colour.red = word0[5:0];
				frame[v][h] = seen;
				if (h == hTotal && v == vTotal)
					frameCount++;
				if (h == hTotal)
				begin
					h = 0;
					v = (v == vTotal) ? 0 : v + 1;
				end
				else
					h++;
				@(negedge bit_clock_out);
			end
		end
		else
		begin
			timeoutErrors++;
			$display("Timeout: clock lane never started after reset");
			finishRun();
		end
	end

	initial
	begin : mainSequence
		reset = 1'b1;
		dotClock = 1'b0;
		dotData = 1'b0;
		dotLatch = 1'b0;
		dotReg = '0;
		repeat (16) @(posedge bit_clock_out);
		reset <= 1'b0;
		clockAndSyncLevels();
		whiteAndBlackBands();
		randomDots();
		bufferHeldUntilLatch();
		extraInputIgnored();
		finishRun();
	end

endmodule

//--- dmdPkg.sv
package dmdPkg;

	localparam int bitSlots = 7;				// Bits per pixel slot on each lane

	typedef logic [7:0] dotByte_t;				// 3-3-2 dot colour, red in the top bits
	typedef logic [13:0] bufAddr_t;				// Top bit picks the bank
	typedef logic [15:0] rasterCount_t;
	typedef logic [15:0] setting_t;
	typedef logic [5:0] colour_t;				// One panel channel, 6 bits
	typedef logic [bitSlots-1:0] laneWord_t;

	typedef struct packed
	{
		colour_t red;
		colour_t green;
		colour_t blue;
	} rgb_t;

	// Raster position plus the panel control levels
	typedef struct packed
	{
		rasterCount_t hPos;
		rasterCount_t vPos;
		logic dataEnable;
		logic hSync;							// Active low
		logic vSync;							// Active low
	} rasterPos_t;

	typedef struct packed
	{
		setting_t whiteEnd;						// White lines after vFront
		setting_t dmdStart;						// First dot line after vFront
		setting_t dmdRows;						// Dot rows drawn
	} dmdSettings_t;

	typedef struct packed
	{
		rgb_t colour;
		logic dataEnable;
		logic hSync;
		logic vSync;
	} pixelOut_t;

	localparam laneWord_t clockLaneWord = 7'b1100011;	// Clock lane pattern, same every pixel
	localparam colour_t whiteLevel = 6'd62;
	localparam colour_t colourScale = 6'd9;				// 3-bit channel up to 6 bits

	localparam dmdSettings_t defaultSettings = '{
		whiteEnd: 16'd50,
		dmdStart: 16'd70,
		dmdRows: 16'd64
	};

endpackage

//--- dotReceiver.sv
module dotReceiver (
	input  logic bit_clock_out,
	input  logic reset,
	input  logic dotClock,
	input  logic dotData,
	input  logic dotLatch,
	input  logic dotReg,
	output logic pixelWrite,
	output dmdPkg::dotByte_t pixelData,
	output logic frameDone,
	output dmdPkg::dmdSettings_t dmdSettings
);

	typedef enum logic {highHalf, lowHalf} half_t;

	logic [1:0] clockSync;						// Two flop synchronisers
	logic [1:0] latchSync;
	logic [1:0] dataSync;
	logic [1:0] regSync;
	logic clockLast;							// For edge detect
	logic latchLast;
	logic clockRise;
	logic latchRise;
	logic [2:0] bitCount;						// Bits taken so far in this byte
	logic [6:0] shiftBits;
	dmdPkg::dotByte_t newByte;
	logic [1:0] settingIndex;					// 3 means all settings filled
	half_t settingHalf;
	dmdPkg::setting_t settingRegs [3];

	assign clockRise = clockSync[1] & ~clockLast;
	assign latchRise = latchSync[1] & ~latchLast;
	assign newByte = {shiftBits, dataSync[1]};	// MSB first, last bit joins here

	// Settings leave as one packed word
	assign dmdSettings = '{
		whiteEnd: settingRegs[0],
		dmdStart: settingRegs[1],
		dmdRows: settingRegs[2]
	};

	always_ff @(posedge bit_clock_out)
	begin
		if (reset)
		begin
			clockSync <= '0;
			latchSync <= '0;
			dataSync <= '0;
			regSync <= '0;
			clockLast <= 1'b0;
			latchLast <= 1'b0;
			pixelWrite <= 1'b0;
			frameDone <= 1'b0;
			bitCount <= '0;
			settingIndex <= '0;
			settingHalf <= highHalf;
			settingRegs[0] <= dmdPkg::defaultSettings.whiteEnd;
			settingRegs[1] <= dmdPkg::defaultSettings.dmdStart;
			settingRegs[2] <= dmdPkg::defaultSettings.dmdRows;
		end
		else
		begin
			clockSync <= {clockSync[0], dotClock};
			latchSync <= {latchSync[0], dotLatch};
			dataSync <= {dataSync[0], dotData};
			regSync <= {regSync[0], dotReg};
			clockLast <= clockSync[1];
			latchLast <= latchSync[1];
			pixelWrite <= 1'b0;
			frameDone <= latchRise;				// One pulse per latch

			if (latchSync[1])					// Latch high clears the byte framing
			begin
				bitCount <= '0;
				settingIndex <= '0;
				settingHalf <= highHalf;
			end
			else if (clockRise)
			begin
				bitCount <= bitCount + 3'd1;	// Wraps to 0 after the eighth bit
				if (bitCount == 3'd7)
				begin
					if (!regSync[1])
						pixelWrite <= 1'b1;		// Dot byte
					else if (settingIndex != 2'd3)
					begin
						if (settingHalf == highHalf)
							settingRegs[settingIndex][15:8] <= newByte;
						else
						begin
							settingRegs[settingIndex][7:0] <= newByte;
							settingIndex <= settingIndex + 2'd1;
						end
						settingHalf <= (settingHalf == highHalf) ? lowHalf : highHalf;
					end
				end
			end
		end
	end

	// Byte shifter and output byte
	always_ff @(posedge bit_clock_out)
	begin
		if (clockRise && !latchSync[1])
		begin
			shiftBits <= newByte[6:0];
			if (bitCount == 3'd7)
				pixelData <= newByte;
		end
	end

endmodule

//--- frameBuffer.sv
module frameBuffer (
	input  logic bit_clock_out,
	input  logic reset,
	input  logic pixelWrite,
	input  dmdPkg::dotByte_t pixelData,
	input  logic frameDone,
	input  dmdPkg::bufAddr_t readAddr,
	output dmdPkg::dotByte_t readData
);

	localparam int addrBits = $bits(dmdPkg::bufAddr_t);
	localparam int offsetBits = addrBits - 1;	// Address bits within one bank

	dmdPkg::dotByte_t memory [2**addrBits];
	logic displayBank;							// Bank being drawn, the other one fills
	logic [offsetBits-1:0] writeOffset;
	dmdPkg::bufAddr_t writeAddr;
	dmdPkg::bufAddr_t displayBase;

	assign writeAddr = {~displayBank, writeOffset};
	assign displayBase = {displayBank, {offsetBits{1'b0}}};

	// Bank flag and fill pointer
	always_ff @(posedge bit_clock_out)
	begin
		if (reset)
		begin
			displayBank <= 1'b0;				// Show bank 0, fill bank 1
			writeOffset <= '0;
		end
		else if (frameDone)
		begin
			displayBank <= ~displayBank;		// Swap banks on latch
			writeOffset <= '0;					// Restart at base of new fill bank
		end
		else if (pixelWrite)
			writeOffset <= writeOffset + 1'b1;
	end

	// Memory, registered read
	always_ff @(posedge bit_clock_out)
	begin
		if (pixelWrite)
			memory[writeAddr] <= pixelData;
		readData <= memory[readAddr + displayBase];	// Offset into display bank
	end

endmodule

//--- lvdsSerializer.sv
module lvdsSerializer (
	input  logic bit_clock_out,
	input  logic reset,
	input  logic pixelValid,
	input  dmdPkg::pixelOut_t pixel,
	output logic pairClk,
	output logic pair2,
	output logic pair1,
	output logic pair0
);

	localparam int topBit = dmdPkg::bitSlots - 1;

	dmdPkg::laneWord_t [3:0] lanes;				// Clock lane on top, then lanes 2, 1, 0
	dmdPkg::laneWord_t [3:0] loadWords;

	assign loadWords[3] = dmdPkg::clockLaneWord;
	assign loadWords[2] = {pixel.dataEnable, pixel.vSync, pixel.hSync, pixel.colour.blue[5:2]};
	assign loadWords[1] = {pixel.colour.blue[1:0], pixel.colour.green[5:1]};
	assign loadWords[0] = {pixel.colour.green[0], pixel.colour.red};	// Green LSB above red

	always_ff @(posedge bit_clock_out)
	begin
		if (reset)
			lanes <= '0;
		else if (pixelValid)
			lanes <= loadWords;					// New pixel every slot
		else
		begin
			for (int i = 0; i < 4; i++)
				lanes[i] <= lanes[i] << 1;		// MSB goes out first
		end
	end

	assign pairClk = lanes[3][topBit];
	assign pair2 = lanes[2][topBit];
	assign pair1 = lanes[1][topBit];
	assign pair0 = lanes[0][topBit];

endmodule

//--- pixelFetch.sv
module pixelFetch #(
	parameter dmdPkg::rasterCount_t vFront = 16'd22,
	parameter int dmdWidth = 128,
	parameter int dotPairs = 8,
	parameter int dotLines = 15
) (
	input  logic bit_clock_out,
	input  logic reset,
	input  logic slotStrobe,
	input  dmdPkg::rasterPos_t raster,
	input  dmdPkg::dmdSettings_t dmdSettings,
	output dmdPkg::bufAddr_t readAddr,
	input  dmdPkg::dotByte_t readData,
	output logic pixelValid,
	output dmdPkg::pixelOut_t pixel
);

	typedef enum logic [1:0] {bandBlack, bandWhite, bandDot} band_t;

	dmdPkg::rasterCount_t subCol;				// Slot within the current dot
	dmdPkg::rasterCount_t dotCol;
	dmdPkg::rasterCount_t subRow;				// Line within the current dot row
	dmdPkg::rasterCount_t dotRow;
	logic [16:0] whiteLimit;					// One extra bit so the sums never wrap
	logic [16:0] dotLimit;
	logic inWhite;
	logic inDot;
	band_t band;
	band_t bandSel;								// Band held for the read cycle
	logic stageValid;
	logic stageDe;
	logic stageHSync;
	logic stageVSync;
	dmdPkg::rgb_t dotColour;
	dmdPkg::rgb_t bandColour;

	assign whiteLimit = 17'(vFront) + 17'(dmdSettings.whiteEnd);
	assign dotLimit = 17'(vFront) + 17'(dmdSettings.dmdStart);
	assign inWhite = {1'b0, raster.vPos} < whiteLimit;
	assign inDot = ({1'b0, raster.vPos} >= dotLimit) && (dotRow < dmdSettings.dmdRows)
		&& (dotCol < dmdWidth);

	// Counters already describe this slot, so the read goes out now
	assign readAddr = dmdPkg::bufAddr_t'(dotRow * dmdWidth + dotCol);

	always_comb
	begin
		if (!raster.dataEnable)
			band = bandBlack;					// Porches and sync
		else if (inWhite)
			band = bandWhite;
		else if (inDot)
			band = bandDot;
		else
			band = bandBlack;					// Gap above the dots, or past the dot area
	end

	// 3-3-2 up to 6-6-6, blue gets an extra bit first
	assign dotColour.red = dmdPkg::colour_t'(readData[7:5]) * dmdPkg::colourScale;
	assign dotColour.green = dmdPkg::colour_t'(readData[4:2]) * dmdPkg::colourScale;
	assign dotColour.blue = dmdPkg::colour_t'({readData[1:0], 1'b0}) * dmdPkg::colourScale;

	always_comb
	begin
		case (bandSel)
			bandWhite: bandColour = '{dmdPkg::whiteLevel, dmdPkg::whiteLevel, dmdPkg::whiteLevel};
			bandDot: bandColour = dotColour;
			default: bandColour = '0;
		endcase
	end

	always_ff @(posedge bit_clock_out)
	begin
		if (reset)
		begin
			subCol <= '0;
			dotCol <= '0;
			subRow <= '0;
			dotRow <= '0;
			stageValid <= 1'b0;
			pixelValid <= 1'b0;
		end
		else
		begin
			stageValid <= slotStrobe;			// Read in flight
			pixelValid <= stageValid;			// Two cycles after the slot
			if (slotStrobe)
			begin
				if (!raster.dataEnable)			// Columns restart each line
				begin
					subCol <= '0;
					dotCol <= '0;
				end
				else if (subCol == dmdPkg::rasterCount_t'(dotPairs - 1))
				begin
					subCol <= '0;
					dotCol <= dotCol + 16'd1;
				end
				else
					subCol <= subCol + 16'd1;

				if (raster.hPos == '0)			// First slot of a line
				begin
					if (raster.vPos == '0)		// Frame start
					begin
						subRow <= '0;
						dotRow <= '0;
					end
					else if ({1'b0, raster.vPos} > dotLimit)	// Line above was a dot line
					begin
						if (subRow == dmdPkg::rasterCount_t'(dotLines - 1))
						begin
							subRow <= '0;
							dotRow <= dotRow + 16'd1;
						end
						else
							subRow <= subRow + 16'd1;
					end
				end
			end
		end
	end

	// Band and levels wait one cycle for the memory
	always_ff @(posedge bit_clock_out)
	begin
		if (slotStrobe)
		begin
			bandSel <= band;
			stageDe <= raster.dataEnable;
			stageHSync <= raster.hSync;
			stageVSync <= raster.vSync;
		end
		if (stageValid)
		begin
			pixel.colour <= bandColour;
			pixel.dataEnable <= stageDe;
			pixel.hSync <= stageHSync;
			pixel.vSync <= stageVSync;
		end
	end

endmodule

//--- rasterTiming.sv
module rasterTiming #(
	parameter dmdPkg::rasterCount_t hFront = 16'd37,
	parameter dmdPkg::rasterCount_t hBack = 16'd998,
	parameter dmdPkg::rasterCount_t hSync = 16'd1024,
	parameter dmdPkg::rasterCount_t hTotal = 16'd1039,
	parameter dmdPkg::rasterCount_t vFront = 16'd22,
	parameter dmdPkg::rasterCount_t vBack = 16'd1104,
	parameter dmdPkg::rasterCount_t vSyncStart = 16'd1107,
	parameter dmdPkg::rasterCount_t vTotal = 16'd1111
) (
	input  logic bit_clock_out,
	input  logic reset,
	output logic slotStrobe,
	output dmdPkg::rasterPos_t raster
);

	localparam int slotBits = $clog2(dmdPkg::bitSlots);

	logic [slotBits-1:0] slotCount;				// Bit within the current pixel slot
	logic slotWrap;
	dmdPkg::rasterCount_t hNext;
	dmdPkg::rasterCount_t vNext;

	// Position plus levels for a given h and v
	function automatic dmdPkg::rasterPos_t levelsAt(
		input dmdPkg::rasterCount_t h,
		input dmdPkg::rasterCount_t v
	);
		dmdPkg::rasterPos_t pos;
		pos.hPos = h;
		pos.vPos = v;
		pos.dataEnable = (h > hFront) && (h < hBack) && (v > vFront) && (v < vBack);
		pos.hSync = !(h >= hSync);				// Low through the end of the line
		pos.vSync = !(v >= vSyncStart);			// Low on the last lines of the frame
		return pos;
	endfunction

	assign slotWrap = (slotCount == slotBits'(dmdPkg::bitSlots - 1));
	assign hNext = (raster.hPos == hTotal) ? '0 : raster.hPos + 16'd1;

	always_comb
	begin
		vNext = raster.vPos;
		if (raster.hPos == hTotal)				// Line done
			vNext = (raster.vPos == vTotal) ? '0 : raster.vPos + 16'd1;
	end

	always_ff @(posedge bit_clock_out)
	begin
		if (reset)
		begin
			slotCount <= '0;
			slotStrobe <= 1'b0;
			raster <= levelsAt('0, '0);
		end
		else
		begin
			slotStrobe <= slotWrap;
			if (slotWrap)
			begin
				slotCount <= '0;
				raster <= levelsAt(hNext, vNext);	// New slot, counters and levels together
			end
			else
				slotCount <= slotCount + 1'b1;
		end
	end

endmodule

//--- sources.f
dmdPkg.sv
dotReceiver.sv
frameBuffer.sv
rasterTiming.sv
pixelFetch.sv
lvdsSerializer.sv
dmdDriver.sv
dmdDriverTb.sv
